// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = nice_core_tb
DUT_TOP   = nice_core
FILELIST  = nice_core.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/nice_core.sv
`timescale 1ns/10ps
////////////////////
// nice coprocessor top
// custom-3 row buffer engine beside the core, built from
// control, row buffer, rowsum datapath and memory address
////////////////////
module nice_core (
   input  logic            nice_clk,
   input  logic            reset,
   output logic            nice_active,
   output logic            nice_mem_holdup,
   // core request
   input  logic            nice_req_valid,
   output logic            nice_req_ready,
   input  nice_pkg::word_t nice_req_inst,
   input  nice_pkg::addr_t nice_req_rs1,
   input  nice_pkg::word_t nice_req_rs2,
   // core response
   output logic            nice_rsp_valid,
   input  logic            nice_rsp_ready,
   output nice_pkg::word_t nice_rsp_rdat,
   output logic            nice_rsp_err,
   // memory command
   output logic            nice_icb_cmd_valid,
   input  logic            nice_icb_cmd_ready,
   output nice_pkg::addr_t nice_icb_cmd_addr,
   output logic            nice_icb_cmd_read,
   output nice_pkg::word_t nice_icb_cmd_wdata,
   // memory response
   input  logic            nice_icb_rsp_valid,
   input  nice_pkg::word_t nice_icb_rsp_rdata,
   input  logic            nice_icb_rsp_err
);
   import nice_pkg::*;

   nice_state_e state;
   logic        is_lbuf;
   logic        is_sbuf;
   logic        is_rowsum;
   logic        cmd_fire;
   logic        rsp_fire;
   row_idx_t    lbuf_idx;
   row_idx_t    sbuf_idx;
   row_idx_t    rsp_idx;
   logic        rcv_valid;
   row_idx_t    rcv_idx;
   word_t       rcv_data;
   logic        acc_busy;
   word_t       row_word;
   logic        lbuf_wr;
   logic        rowsum_beat;
   logic        rsp_done;

   // per-instruction beat strobes
   assign lbuf_wr     = (state == ST_LBUF) & rsp_fire;
   assign rowsum_beat = (state == ST_ROWSUM) & rsp_fire;
   assign rsp_done    = nice_rsp_valid & nice_rsp_ready;

   // rs2 is part of the R-type format but no instruction reads it
   nice_ctrl u_ctrl (.*);

   nice_row_buf u_row_buf (
      .lbuf_data (nice_icb_rsp_rdata),
      .*
   );

   nice_rowsum_unit u_rowsum (.*);

   nice_mem_addr u_mem_addr (.*);

endmodule

// File: logic/nice_ctrl.sv
`timescale 1ns/10ps
////////////////////
// nice control
// decodes custom-3 lbuf, sbuf and rowsum, runs the state
// machine and beat counters, drives core and memory strobes
////////////////////
module nice_ctrl (
   input  logic                  nice_clk,
   input  logic                  reset,
   input  logic                  nice_req_valid,
   input  nice_pkg::word_t       nice_req_inst,
   input  logic                  nice_rsp_ready,
   input  logic                  nice_icb_cmd_ready,
   input  logic                  nice_icb_rsp_valid,
   input  logic                  nice_icb_rsp_err,
   input  logic                  rcv_valid,
   input  nice_pkg::row_idx_t    rcv_idx,
   input  logic                  acc_busy,
   output logic                  nice_req_ready,
   output logic                  nice_rsp_valid,
   output logic                  nice_rsp_err,
   output logic                  nice_icb_cmd_valid,
   output logic                  nice_active,
   output logic                  nice_mem_holdup,
   output nice_pkg::nice_state_e state,
   output logic                  is_lbuf,
   output logic                  is_sbuf,
   output logic                  is_rowsum,
   output logic                  cmd_fire,
   output logic                  rsp_fire,
   output nice_pkg::row_idx_t    lbuf_idx,
   output nice_pkg::row_idx_t    sbuf_idx,
   output nice_pkg::row_idx_t    rsp_idx
);
   import nice_pkg::*;

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic        mem_op;
   logic        st_idle;
   logic        st_buf;
   logic        st_rowsum;
   logic        rsp_last;
   logic        rowsum_rsp_valid;
   logic        insn_done;
   logic        sum_wait;
   row_idx_t    rsp_cnt;
   row_idx_t    cmd_cnt;
   nice_state_e state_nxt;

   ////////////////////
   // decode
   ////////////////////
   assign opcode = nice_req_inst[6:0];
   assign funct3 = nice_req_inst[14:12];
   assign funct7 = nice_req_inst[31:25];

   // flags only mean something while a request is offered
   assign is_lbuf   = nice_req_valid & (opcode == OPCODE_CUSTOM3) &
                      (funct3 == FUNCT3_BUF) & (funct7 == FUNCT7_LBUF);
   assign is_sbuf   = nice_req_valid & (opcode == OPCODE_CUSTOM3) &
                      (funct3 == FUNCT3_BUF) & (funct7 == FUNCT7_SBUF);
   assign is_rowsum = nice_req_valid & (opcode == OPCODE_CUSTOM3) &
                      (funct3 == FUNCT3_ROWSUM) & (funct7 == FUNCT7_ROWSUM);
   assign mem_op    = is_lbuf | is_sbuf | is_rowsum;

   assign st_idle   = (state == ST_IDLE);
   assign st_buf    = (state == ST_LBUF) | (state == ST_SBUF);
   assign st_rowsum = (state == ST_ROWSUM);

   ////////////////////
   // strobes
   ////////////////////
   // first command leaves with the request, so ready waits on memory
   assign nice_req_ready = st_idle & (mem_op ? nice_icb_cmd_ready : 1'b1);
   assign cmd_fire       = nice_icb_cmd_valid & nice_icb_cmd_ready;
   // memory responses are always taken
   assign rsp_fire       = nice_icb_rsp_valid;
   assign rsp_last       = rsp_fire & (rsp_cnt == ROW_LAST);

   // rowsum answers once the last word has left the add stage
   assign rowsum_rsp_valid = st_rowsum & (rcv_idx == ROW_LAST) & ~acc_busy;
   assign nice_rsp_valid   = (st_buf & rsp_last) | rowsum_rsp_valid;
   assign nice_rsp_err     = rsp_fire & nice_icb_rsp_err;
   assign insn_done        = (st_buf & rsp_last) | (rowsum_rsp_valid & nice_rsp_ready);

   // lbuf/sbuf stream commands, rowsum waits for each word to be summed
   assign nice_icb_cmd_valid = (st_idle & mem_op) |
                               (st_buf & (cmd_cnt <= ROW_LAST)) |
                               (st_rowsum & (cmd_cnt <= ROW_LAST) & ~sum_wait);

   assign nice_active     = st_idle ? nice_req_valid : 1'b1;
   assign nice_mem_holdup = ~st_idle;

   // lbuf beats index the row directly
   assign lbuf_idx = rsp_cnt;
   assign rsp_idx  = rsp_cnt;
   // next store word follows the command count
   assign sbuf_idx = cmd_cnt;

   ////////////////////
   // fsm
   ////////////////////
   always_comb begin
      state_nxt = state;
      if (st_idle) begin
         if (nice_req_valid & nice_req_ready & mem_op) begin
            state_nxt = is_lbuf ? ST_LBUF : (is_sbuf ? ST_SBUF : ST_ROWSUM);
         end
      end else if (insn_done) begin
         state_nxt = ST_IDLE;
      end
   end

   always_ff @(posedge nice_clk) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // response beat counter, wraps after the last beat
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         rsp_cnt <= '0;
      end else if (rsp_fire & ~st_idle) begin
         rsp_cnt <= (rsp_cnt == ROW_LAST) ? '0 : rsp_cnt + row_idx_t'(1);
      end
   end

   // command counter, counts up to one past the last beat
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         cmd_cnt <= '0;
      end else if (insn_done) begin
         cmd_cnt <= '0;
      end else if (cmd_fire) begin
         cmd_cnt <= cmd_cnt + row_idx_t'(1);
      end
   end

   // rowsum word in flight, cleared when it reaches the accumulator
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         sum_wait <= 1'b0;
      end else if (cmd_fire & (st_rowsum | (st_idle & is_rowsum))) begin
         sum_wait <= 1'b1;
      end else if (rcv_valid) begin
         sum_wait <= 1'b0;
      end
   end

endmodule

// File: logic/nice_mem_addr.sv
`timescale 1ns/10ps
////////////////////
// nice memory address
// word address accumulator plus the memory command
// address, read flag and store data
////////////////////
module nice_mem_addr (
   input  logic                  nice_clk,
   input  logic                  reset,
   input  nice_pkg::nice_state_e state,
   input  logic                  is_lbuf,
   input  logic                  is_sbuf,
   input  logic                  is_rowsum,
   input  nice_pkg::addr_t       nice_req_rs1,
   input  logic                  cmd_fire,
   input  nice_pkg::word_t       row_word,
   output nice_pkg::addr_t       nice_icb_cmd_addr,
   output logic                  nice_icb_cmd_read,
   output nice_pkg::word_t       nice_icb_cmd_wdata
);
   import nice_pkg::*;

   logic  st_idle;
   addr_t addr_q;
   addr_t addr_cur;

   assign st_idle = (state == ST_IDLE);

   // first beat goes straight out on rs1
   assign addr_cur = st_idle ? nice_req_rs1 : addr_q;

   // step one word per accepted command
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         addr_q <= '0;
      end else if (cmd_fire) begin
         addr_q <= addr_cur + WORD_BYTES;
      end
   end

   assign nice_icb_cmd_addr  = addr_cur;
   // only sbuf writes
   assign nice_icb_cmd_read  = st_idle ? (is_lbuf | is_rowsum) : (state != ST_SBUF);
   assign nice_icb_cmd_wdata = ((st_idle & is_sbuf) | (state == ST_SBUF)) ? row_word : '0;

endmodule

// File: logic/nice_pkg.sv
////////////////////
// nice coprocessor shared definitions
// widths, custom-3 instruction codes, row constants
// and the control state type
////////////////////
package nice_pkg;

   // data word or instruction, and byte address
   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   // row buffer entry and beat index
   typedef logic [1:0]  row_idx_t;

   // row buffer holds one spare entry past the last beat
   localparam int       ROW_DEPTH  = 4;
   localparam row_idx_t ROW_LAST   = 2'd2;
   // full word accesses only
   localparam addr_t    WORD_BYTES = 32'd4;

   // custom-3 R-type encodings
   localparam logic [6:0] OPCODE_CUSTOM3 = 7'b1111011;
   localparam logic [2:0] FUNCT3_BUF     = 3'b010;
   localparam logic [2:0] FUNCT3_ROWSUM  = 3'b110;
   localparam logic [6:0] FUNCT7_LBUF    = 7'b0000001;
   localparam logic [6:0] FUNCT7_SBUF    = 7'b0000010;
   localparam logic [6:0] FUNCT7_ROWSUM  = 7'b0000110;

   // one state per multi-cycle instruction
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_LBUF   = 2'd1,
      ST_SBUF   = 2'd2,
      ST_ROWSUM = 2'd3
   } nice_state_e;

endpackage

// File: logic/nice_row_buf.sv
`timescale 1ns/10ps
////////////////////
// nice row buffer
// four word row, written by lbuf beats and rowsum
// accumulation, read for sbuf stores
////////////////////
module nice_row_buf (
   input  logic               nice_clk,
   input  logic               reset,
   input  logic               lbuf_wr,
   input  nice_pkg::row_idx_t lbuf_idx,
   input  nice_pkg::word_t    lbuf_data,
   input  logic               rcv_valid,
   input  nice_pkg::row_idx_t rcv_idx,
   input  nice_pkg::word_t    rcv_data,
   input  nice_pkg::row_idx_t sbuf_idx,
   output nice_pkg::word_t    row_word
);
   import nice_pkg::*;

   word_t    row_q [ROW_DEPTH];
   logic     wr_en;
   row_idx_t wr_idx;
   word_t    wr_data;

   // write select, lbuf and rowsum never overlap
   assign wr_en   = lbuf_wr | rcv_valid;
   assign wr_idx  = lbuf_wr ? lbuf_idx : rcv_idx;
   // rowsum adds the registered word onto the stored entry
   assign wr_data = lbuf_wr ? lbuf_data : (row_q[rcv_idx] + rcv_data);

   always_ff @(posedge nice_clk) begin
      if (reset) begin
         for (int i = 0; i < ROW_DEPTH; i++) begin
            row_q[i] <= '0;
         end
      end else if (wr_en) begin
         row_q[wr_idx] <= wr_data;
      end
   end

   // store data port
   assign row_word = row_q[sbuf_idx];

endmodule

// File: logic/nice_rowsum_unit.sv
`timescale 1ns/10ps
////////////////////
// nice rowsum datapath
// registers each rowsum word with its beat index and
// sums the row into the result accumulator
////////////////////
module nice_rowsum_unit (
   input  logic               nice_clk,
   input  logic               reset,
   input  logic               rowsum_beat,
   input  nice_pkg::row_idx_t rsp_idx,
   input  nice_pkg::word_t    nice_icb_rsp_rdata,
   input  logic               rsp_done,
   output logic               rcv_valid,
   output nice_pkg::row_idx_t rcv_idx,
   output nice_pkg::word_t    rcv_data,
   output logic               acc_busy,
   output nice_pkg::word_t    nice_rsp_rdat
);
   import nice_pkg::*;

   word_t acc_q;
   logic  sum_active;

   // receive buffer control, index held until the result is taken
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         rcv_valid  <= 1'b0;
         rcv_idx    <= '0;
         sum_active <= 1'b0;
      end else begin
         rcv_valid <= rowsum_beat;
         if (rowsum_beat) begin
            rcv_idx    <= rsp_idx;
            sum_active <= 1'b1;
         end else if (rsp_done) begin
            rcv_idx    <= '0;
            sum_active <= 1'b0;
         end
      end
   end

   // received word, so the adders work from registers
   always_ff @(posedge nice_clk) begin
      if (rowsum_beat) begin
         rcv_data <= nice_icb_rsp_rdata;
      end
   end

   // beat 0 loads, later beats add
   always_ff @(posedge nice_clk) begin
      if (rcv_valid) begin
         acc_q <= (rcv_idx == '0) ? rcv_data : (acc_q + rcv_data);
      end
   end

   // an add is still pending this cycle
   assign acc_busy = rcv_valid & (rcv_idx != '0);

   // result only shown during a rowsum
   assign nice_rsp_rdat = sum_active ? acc_q : '0;

endmodule

// File: nice_core.f
logic/nice_pkg.sv
logic/nice_ctrl.sv
logic/nice_row_buf.sv
logic/nice_rowsum_unit.sv
logic/nice_mem_addr.sv
logic/nice_core.sv
testbench/nice_mem_model.sv
testbench/nice_core_assertions.sv
testbench/nice_core_tb.sv

// File: testbench/nice_core_assertions.sv
`timescale 1ns/10ps
////////////////////
// nice core assertions
// reset state, busy outputs and command stability
////////////////////
module nice_core_assertions (
   input logic            nice_clk,
   input logic            reset,
   input logic            nice_req_valid,
   input logic            nice_req_ready,
   input logic            nice_rsp_valid,
   input logic            nice_icb_cmd_valid,
   input logic            nice_icb_cmd_ready,
   input nice_pkg::addr_t nice_icb_cmd_addr,
   input logic            nice_mem_holdup,
   input logic            nice_active
);
   // nothing pending right after reset
   a_reset_quiet: assert property (@(posedge nice_clk)
      reset |=> (!nice_rsp_valid && !nice_icb_cmd_valid))
      else $error("response or command valid after reset");

   // an accepted memory instruction leaves idle, so both busy outputs rise
   a_holdup_active: assert property (@(posedge nice_clk) disable iff (reset)
      (nice_req_valid && nice_req_ready && nice_icb_cmd_valid) |=>
         (nice_mem_holdup && nice_active))
      else $error("memory holdup or active low after an accepted instruction");

   // stalled command keeps its address
   a_cmd_stable: assert property (@(posedge nice_clk) disable iff (reset)
      (nice_icb_cmd_valid && !nice_icb_cmd_ready) |=>
         (nice_icb_cmd_valid && $stable(nice_icb_cmd_addr)))
      else $error("stalled command dropped or address changed");

endmodule

// File: testbench/nice_core_tb.sv
`timescale 1ns/10ps
////////////////////
// nice core testbench
// table of custom-3 instructions against a memory model
// with a reference copy of memory and row buffer
////////////////////
module nice_core_tb;
   import nice_pkg::*;

   localparam int         N_TESTS  = 10;
   localparam logic [1:0] K_LBUF   = 2'd0;
   localparam logic [1:0] K_SBUF   = 2'd1;
   localparam logic [1:0] K_ROWSUM = 2'd2;
   localparam logic [1:0] K_OTHER  = 2'd3;

   typedef struct packed {
      logic [1:0] kind;
      addr_t      rs1;
      logic       rsp_exp;
      logic [2:0] hold;
   } test_row_t;

   logic  nice_clk, reset, nice_active, nice_mem_holdup;
   logic  nice_req_valid, nice_req_ready, nice_rsp_valid, nice_rsp_ready, nice_rsp_err;
   word_t nice_req_inst, nice_req_rs2, nice_rsp_rdat;
   addr_t nice_req_rs1, nice_icb_cmd_addr;
   logic  nice_icb_cmd_valid, nice_icb_cmd_ready, nice_icb_cmd_read;
   word_t nice_icb_cmd_wdata, nice_icb_rsp_rdata;
   logic  nice_icb_rsp_valid, nice_icb_rsp_err;

   test_row_t tbl [N_TESTS];
   word_t     ref_mem [256];
   word_t     ref_row [3];
   addr_t     cmd_q [$];
   logic      rd_q [$];
   int        err_seen, rsp_seen, errors, checks;

   nice_core dut0 (.*);

   nice_mem_model mem0 (
      .nice_clk  (nice_clk),
      .reset     (reset),
      .cmd_valid (nice_icb_cmd_valid),
      .cmd_ready (nice_icb_cmd_ready),
      .cmd_addr  (nice_icb_cmd_addr),
      .cmd_read  (nice_icb_cmd_read),
      .cmd_wdata (nice_icb_cmd_wdata),
      .rsp_valid (nice_icb_rsp_valid),
      .rsp_rdata (nice_icb_rsp_rdata),
      .rsp_err   (nice_icb_rsp_err)
   );

   bind nice_core nice_core_assertions u_assert (.*);

   initial begin
      nice_clk = 1'b0;
      forever #10 nice_clk = ~nice_clk;
   end

   // watchdog allows 40 cycles per table row
   initial begin
      #((N_TESTS * 40 + 5) * 20);
      $display("timeout: the tests did not finish in time");
      $display("TESTBENCH FAILED");
      $finish;
   end

   // bus monitors sample mid-cycle
   always @(negedge nice_clk) begin
      if (!reset) begin
         if (nice_icb_cmd_valid && nice_icb_cmd_ready) begin
            cmd_q.push_back(nice_icb_cmd_addr);
            rd_q.push_back(nice_icb_cmd_read);
         end
         if (nice_rsp_err) err_seen++;
         if (nice_rsp_valid && nice_rsp_ready) rsp_seen++;
      end
   end

   ////////////////////
   // checks and helpers
   ////////////////////
   task automatic check_word(input word_t got, input word_t exp, input string msg);
      checks++;
      if (got !== exp) begin
         $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input addr_t got, input addr_t exp, input string msg);
      checks++;
      if (got !== exp) begin
         $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string msg);
      checks++;
      if (got !== exp) begin
         $display("FAIL %0t: %s got %b expected %b", $time, msg, got, exp);
         errors++;
      end
   endtask

   // top 16 words of the model flag errors
   function automatic logic in_err(input addr_t a);
      return a[9:2] >= 8'hf0;
   endfunction

   function automatic word_t make_inst(input logic [1:0] kind);
      word_t inst;
      // rd x5, rs1 x6, rs2 x7
      inst = {7'd0, 5'd7, 5'd6, 3'd0, 5'd5, OPCODE_CUSTOM3};
      case (kind)
         K_LBUF:   inst = {FUNCT7_LBUF, inst[24:15], FUNCT3_BUF, inst[11:0]};
         K_SBUF:   inst = {FUNCT7_SBUF, inst[24:15], FUNCT3_BUF, inst[11:0]};
         K_ROWSUM: inst = {FUNCT7_ROWSUM, inst[24:15], FUNCT3_ROWSUM, inst[11:0]};
         default:  inst[6:0] = 7'b0110011;
      endcase
      return inst;
   endfunction

   task automatic run_test(input int n);
      test_row_t row;
      int        cmd_base, err_base, rsp_base, err_before, exp_err;
      word_t     exp_sum;
      addr_t     a;
      row = tbl[n];
      err_before = errors;
      cmd_base = cmd_q.size();
      err_base = err_seen;
      rsp_base = rsp_seen;
      exp_sum = '0;
      exp_err = 0;
      // reference effect of the instruction
      for (int k = 0; k < 3; k++) begin
         a = row.rs1 + addr_t'(k) * WORD_BYTES;
         if (row.kind != K_OTHER && in_err(a)) exp_err++;
         case (row.kind)
            K_LBUF:   ref_row[k] = ref_mem[a[9:2]];
            K_SBUF:   ref_mem[a[9:2]] = ref_row[k];
            K_ROWSUM: begin
               exp_sum = exp_sum + ref_mem[a[9:2]];
               ref_row[k] = ref_row[k] + ref_mem[a[9:2]];
            end
            default: ;
         endcase
      end
      nice_rsp_ready = (row.hold == 3'd0);
      nice_req_inst = make_inst(row.kind);
      nice_req_rs1 = row.rs1;
      nice_req_valid = 1'b1;
      @(negedge nice_clk);
      while (!nice_req_ready) @(negedge nice_clk);
      // idle with a request offered
      check_flag(nice_active, 1'b1, "active with request");
      check_flag(nice_mem_holdup, 1'b0, "holdup while idle");
      @(posedge nice_clk);
      #2 nice_req_valid = 1'b0;
      if (row.rsp_exp) begin
         @(negedge nice_clk);
         while (!nice_rsp_valid) @(negedge nice_clk);
         // busy outside idle, request already withdrawn
         check_flag(nice_active, 1'b1, "active while busy");
         check_flag(nice_mem_holdup, 1'b1, "holdup while busy");
         if (row.kind == K_ROWSUM) begin
            check_word(nice_rsp_rdat, exp_sum, "rowsum result");
            // response must wait for ready
            for (int i = 0; i < int'(row.hold); i++) begin
               @(negedge nice_clk);
               check_flag(nice_rsp_valid, 1'b1, "rsp_valid held");
               check_word(nice_rsp_rdat, exp_sum, "rowsum result held");
            end
            if (row.hold != 3'd0) begin
               @(posedge nice_clk);
               #2 nice_rsp_ready = 1'b1;
               @(negedge nice_clk);
               check_flag(nice_rsp_valid, 1'b1, "rsp_valid at ready");
            end
         end
         @(posedge nice_clk);
         #2;
      end else begin
         repeat (4) @(posedge nice_clk);
         #2;
      end
      // back in idle with no request
      check_flag(nice_active, 1'b0, "active after end");
      check_flag(nice_mem_holdup, 1'b0, "holdup after end");
      check_word(word_t'(cmd_q.size() - cmd_base), row.rsp_exp ? 32'd3 : 32'd0, "command count");
      for (int k = 0; k < 3 && cmd_base + k < cmd_q.size(); k++) begin
         check_addr(cmd_q[cmd_base + k], row.rs1 + addr_t'(k) * WORD_BYTES, "command address");
         check_flag(rd_q[cmd_base + k], row.kind != K_SBUF, "command read");
      end
      check_word(word_t'(err_seen - err_base), word_t'(exp_err), "error beats");
      check_word(word_t'(rsp_seen - rsp_base), row.rsp_exp ? 32'd1 : 32'd0, "responses");
      if (row.kind == K_SBUF) begin
         for (int k = 0; k < 3; k++) begin
            a = row.rs1 + addr_t'(k) * WORD_BYTES;
            check_word(mem0.mem[a[9:2]], ref_mem[a[9:2]], "stored word");
         end
      end
      $display("test %0d kind %0d rs1 %h: %s", n, row.kind, row.rs1,
               (errors == err_before) ? "ok" : "errors");
   endtask

   ////////////////////
   // main sequence
   ////////////////////
   initial begin
      void'($urandom(32'h3e74));
      reset = 1'b1;
      nice_req_valid = 1'b0;
      nice_req_inst = '0;
      nice_req_rs1 = '0;
      nice_req_rs2 = '0;
      nice_rsp_ready = 1'b1;
      errors = 0;
      checks = 0;
      err_seen = 0;
      rsp_seen = 0;
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = (word_t'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
      end
      for (int k = 0; k < 3; k++) ref_row[k] = '0;
      // kind, rs1, response expected, ready hold cycles
      tbl[0] = '{K_LBUF,   32'h0000_0040, 1'b1, 3'd0};
      tbl[1] = '{K_SBUF,   32'h0000_0100, 1'b1, 3'd0};
      tbl[2] = '{K_ROWSUM, 32'h0000_0080, 1'b1, 3'd0};
      tbl[3] = '{K_SBUF,   32'h0000_0140, 1'b1, 3'd0};
      tbl[4] = '{K_ROWSUM, 32'h0000_00c0, 1'b1, 3'd3};
      tbl[5] = '{K_LBUF,   32'h0000_03bc, 1'b1, 3'd0};
      tbl[6] = '{K_OTHER,  32'h0000_0060, 1'b0, 3'd0};
      tbl[7] = '{K_LBUF,   32'h0000_0020, 1'b1, 3'd0};
      tbl[8] = '{K_SBUF,   32'h0000_0200, 1'b1, 3'd0};
      tbl[9] = '{K_ROWSUM, 32'h0000_03e0, 1'b1, 3'd1};
      repeat (5) @(posedge nice_clk);
      #2 reset = 1'b0;
      @(posedge nice_clk);
      #2;
      for (int n = 0; n < N_TESTS; n++) run_test(n);
      $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: testbench/nice_mem_model.sv
`timescale 1ns/10ps
////////////////////
// word memory model
// random command stalls, response one cycle after the
// command, error flag for the top 16 words
////////////////////
module nice_mem_model (
   input  logic            nice_clk,
   input  logic            reset,
   input  logic            cmd_valid,
   output logic            cmd_ready,
   input  nice_pkg::addr_t cmd_addr,
   input  logic            cmd_read,
   input  nice_pkg::word_t cmd_wdata,
   output logic            rsp_valid,
   output nice_pkg::word_t rsp_rdata,
   output logic            rsp_err
);
   import nice_pkg::*;

   word_t      mem [256];
   logic [1:0] stall;
   logic [7:0] idx;

   // fill uses every address bit
   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = (word_t'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
      end
   end

   assign idx       = cmd_addr[9:2];
   assign cmd_ready = (stall == 2'd0);

   always @(posedge nice_clk) begin
      if (reset) begin
         stall     <= 2'd0;
         rsp_valid <= 1'b0;
         rsp_err   <= 1'b0;
         rsp_rdata <= '0;
      end else if (cmd_valid && cmd_ready) begin
         // new stall of 0 to 2 cycles before the next command
         stall     <= 2'($urandom % 3);
         rsp_valid <= 1'b1;
         rsp_err   <= (idx >= 8'hf0);
         rsp_rdata <= mem[idx];
         if (!cmd_read) begin
            mem[idx] <= cmd_wdata;
         end
      end else begin
         rsp_valid <= 1'b0;
         rsp_err   <= 1'b0;
         if (stall != 2'd0) begin
            stall <= stall - 2'd1;
         end
      end
   end

endmodule
